// File: astro_controls.f
+incdir+include
hdl/astro_pkg.sv
hdl/game_config.sv
hdl/key_decoder.sv
hdl/switch_matrix.sv
hdl/sample_loader.sv
hdl/audio_mixer.sv
hdl/astro_controls_top.sv
dv/astro_controls_props.sv
dv/astro_controls_tb.sv

// File: dv/astro_controls_tb.sv
/*
 * Testbench for the control front end: game select and audio mix,
 * key and joystick matrix bits, DIP bank and sample loader
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module astro_controls_tb import astro_pkg::*; ();

	localparam int CLK_NS = 10;
	localparam int LOADS = 4;
	localparam int MAX_HOLD = 8;
	// Cycles for DIP and games, keys and sticks, loads, with headroom doubled
	localparam int RUN_CYCLES = 40 + 8 * 40 + 33 * 8 + LOADS * (MAX_HOLD + 8);
	localparam int WATCHDOG_NS = 2 * RUN_CYCLES * CLK_NS;

	logic                     clk_sys = 1'b0;
	logic                     reset = 1'b1;
	logic                     ioctl_download;
	logic                     ioctl_wr;
	logic                     ioctl_wait;
	logic [`ASTRO_ADDR_W-1:0] ioctl_addr;
	logic [`ASTRO_ADDR_W-1:0] mem_addr;
	logic [15:0]              ioctl_dout;
	logic [15:0]              joystick_0;
	logic [15:0]              joystick_1;
	logic [7:0]               ioctl_index;
	logic [7:0]               col_select;
	logic [7:0]               row_data;
	logic [7:0]               chip_l;
	logic [7:0]               chip_r;
	logic [10:0]              ps2_key;
	logic                     speech_busy;
	logic                     wave_rd;
	logic                     mem_ready;
	logic                     mem_we;
	logic                     mem_rd;
	logic [`ASTRO_WAVE_W-1:0] wave_addr;
	logic [15:0]              sample_l;
	logic [15:0]              sample_r;
	logic [15:0]              audio_l;
	logic [15:0]              audio_r;
	logic                     audio_signed;

	logic [7:0] dip_val [8];

	// Key table, column index and row bit under wizard of wor
	logic [8:0] key_code [18] = '{
		{1'b1, `ASTRO_KEY_UP}, {1'b1, `ASTRO_KEY_DOWN}, {1'b1, `ASTRO_KEY_LEFT},
		{1'b1, `ASTRO_KEY_RIGHT}, `ASTRO_KEY_CTRL, `ASTRO_KEY_SPACE,
		`ASTRO_KEY_F1, `ASTRO_KEY_F2, `ASTRO_KEY_F3, `ASTRO_KEY_1, `ASTRO_KEY_2, `ASTRO_KEY_5,
		`ASTRO_KEY_R, `ASTRO_KEY_F, `ASTRO_KEY_D, `ASTRO_KEY_G, `ASTRO_KEY_A, `ASTRO_KEY_S
	};
	int unsigned key_col [18] = '{2, 2, 2, 2, 2, 2, 0, 0, 0, 0, 0, 0, 1, 1, 1, 1, 1, 1};
	int unsigned key_bit [18] = '{0, 1, 2, 3, 5, 4, 5, 6, 1, 5, 6, 1, 0, 1, 2, 3, 5, 4};
	// Joystick 0 bits 0 to 8 under the same game
	int unsigned joy_col [9] = '{2, 2, 2, 2, 2, 2, 0, 0, 0};
	int unsigned joy_bit [9] = '{3, 2, 1, 0, 5, 4, 5, 6, 1};

	astro_controls_top i_astro_controls_top (.*);

	// ==================================================================
	// Reporting helpers
	// ==================================================================
	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp)
		else fail_run($sformatf("** Error: %s expected 0x%0h got 0x%0h", name, exp, got));
	endtask

	// ==================================================================
	// Stimulus helpers
	// ==================================================================
	task automatic download_write(input logic [7:0] idx, input logic [24:0] addr,
		input logic [15:0] data);
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index <= idx;
		ioctl_addr <= addr;
		ioctl_dout <= data;
		ioctl_wr <= 1'b1;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
	endtask

	task automatic read_row(input logic [7:0] col, output logic [7:0] row);
		@(posedge clk_sys);
		col_select <= col;
		@(negedge clk_sys);
		row = row_data;
	endtask

	task automatic check_row_bit(input int unsigned col, input int unsigned bitpos,
		input logic exp);
		logic [7:0] row;
		read_row(8'h01 << col, row);
		check_value($sformatf("row_data[%0d] col %0d", bitpos, col), row[bitpos], exp);
	endtask

	// New event whenever bit 10 flips
	task automatic key_event(input logic [8:0] code, input logic pressed);
		@(posedge clk_sys);
		ps2_key <= {~ps2_key[10], pressed, code};
	endtask

	// Chip byte over its own top six bits plus speech at a quarter
	function automatic logic [15:0] chip_with_speech(input logic [7:0] chip,
		input logic [15:0] smp);
		logic [15:0] chip_term;
		chip_term = (16'(chip) << 6) | 16'(chip >> 2);
		return chip_term + (smp >> 2);
	endfunction

	// Column 0 with every button released
	function automatic logic [7:0] expected_col0(input game_t g, input logic [7:0] d2);
		case (g)
			GAME_SPACEZAP: return {4'hf, d2[1], 3'b111};
			GAME_GORF: return {d2[2], d2[0], 3'b111, d2[1], 2'b11};
			GAME_WOW: return {d2[2], 3'b111, d2[1], 3'b111};
			GAME_ROBBY: return {1'b0, 3'b111, d2[1], 3'b111};
			default: return 8'hff;
		endcase
	endfunction

	// Columns 1 and 2 with every button released
	function automatic logic [7:0] expected_stick(input game_t g, input int unsigned col,
		input logic [7:0] d2, input logic busy);
		case (g)
			GAME_SPACEZAP: return (col == 1) ? 8'hff : {2'b11, d2[0], 5'h1f};
			GAME_GORF: return (col == 1) ? 8'h3f : {busy, 7'h3f};
			GAME_WOW: return (col == 1) ? 8'hef : {busy, 7'h6f};
			default: return 8'hff;
		endcase
	endfunction

	task automatic check_audio(input game_t g);
		logic [15:0] exp_l;
		logic [15:0] exp_r;
		@(posedge clk_sys);
		chip_l <= 8'($urandom);
		chip_r <= 8'($urandom);
		sample_l <= 16'($urandom);
		sample_r <= 16'($urandom);
		// One cycle of latency
		@(posedge clk_sys);
		@(negedge clk_sys);
		case (g)
			GAME_SEAWOLF2: begin
				exp_l = sample_l;
				exp_r = sample_r;
			end
			GAME_GORF, GAME_WOW: begin
				exp_l = chip_with_speech(chip_l, sample_l);
				exp_r = chip_with_speech(chip_r, sample_r);
			end
			GAME_ROBBY: begin
				exp_l = {chip_l, chip_l};
				exp_r = {chip_r, chip_r};
			end
			default: begin
				exp_l = {chip_l, chip_l};
				exp_r = {chip_l, chip_l};
			end
		endcase
		check_value("audio_l", audio_l, exp_l);
		check_value("audio_r", audio_r, exp_r);
		check_value("audio_signed", audio_signed, g == GAME_SEAWOLF2);
	endtask

	// One sample write with memory busy for hold cycles
	task automatic sample_write(input logic [24:0] addr, input int hold);
		int we_count;
		int waited;
		we_count = 0;
		waited = 0;
		@(posedge clk_sys);
		ioctl_addr <= addr;
		ioctl_wr <= 1'b1;
		mem_ready <= 1'b0;
		@(posedge clk_sys);
		ioctl_wr <= 1'b0;
		repeat (hold) begin
			@(negedge clk_sys);
			we_count += mem_we;
			check_value("mem_addr", mem_addr, addr);
			check_value("mem_rd", mem_rd, 1'b0);
		end
		@(posedge clk_sys);
		mem_ready <= 1'b1;
		do begin
			@(negedge clk_sys);
			we_count += mem_we;
			waited++;
		end while (ioctl_wait && waited < 20);
		if (ioctl_wait) begin
			fail_run("ioctl_wait never fell after mem_ready went high");
		end
		check_value("mem_we pulse count", we_count, 1);
	endtask

	// ==================================================================
	// Clock, watchdog, assertion monitor
	// ==================================================================
	initial begin
		forever #(CLK_NS / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(WATCHDOG_NS);
		fail_run($sformatf("Watchdog expired after %0d ns", WATCHDOG_NS));
	end

	always @(negedge clk_sys) begin
		if (i_astro_controls_top.i_astro_controls_props.fail_count != 0) begin
			fail_run("A bound timing assertion failed");
		end
	end

	// ==================================================================
	// Main sequence
	// ==================================================================
	initial begin
		logic [7:0] row;
		logic       active;
		game_t      gsel;
		void'($urandom(25128));
		ioctl_download = 1'b0;
		ioctl_wr = 1'b0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_index = '0;
		ps2_key = '0;
		joystick_0 = '0;
		joystick_1 = '0;
		col_select = '0;
		speech_busy = 1'b0;
		wave_addr = '0;
		wave_rd = 1'b0;
		mem_ready = 1'b1;
		chip_l = '0;
		chip_r = '0;
		sample_l = '0;
		sample_r = '0;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;

		// Load the DIP bank and write past its end without aliasing byte 3
		for (int k = 0; k < 8; k++) begin
			dip_val[k] = 8'($urandom);
			download_write(`ASTRO_IDX_DIP, 25'(k), {8'h00, dip_val[k]});
		end
		download_write(`ASTRO_IDX_DIP, 25'd11, {8'h00, ~dip_val[3]});

		// Every game code including 7
		for (int g = 0; g < 8; g++) begin
			gsel = (g > 6) ? GAME_NONE : game_t'(g);
			download_write(`ASTRO_IDX_GAME, '0, 16'(g));
			repeat (2) @(posedge clk_sys);
			repeat (3) check_audio(gsel);
			read_row(`ASTRO_COL_0, row);
			check_value("row_data col 0", row, expected_col0(gsel, dip_val[2]));
			read_row(`ASTRO_COL_3, row);
			check_value("row_data col 3", row, (gsel == GAME_EBASES) ? 8'hff : dip_val[3]);
			read_row(8'h10, row);
			check_value("row_data col 10", row, 8'hff);
			read_row(8'h03, row);
			check_value("row_data col 03", row, 8'hff);
			read_row(`ASTRO_COL_1, row);
			check_value("row_data col 1", row, expected_stick(gsel, 1, dip_val[2], 1'b0));
			read_row(`ASTRO_COL_2, row);
			check_value("row_data col 2", row, expected_stick(gsel, 2, dip_val[2], 1'b0));
			// Speech status on top of column 2
			@(posedge clk_sys);
			speech_busy <= 1'b1;
			read_row(`ASTRO_COL_2, row);
			check_value("row_data col 2 busy", row,
				expected_stick(gsel, 2, dip_val[2], 1'b1));
			@(posedge clk_sys);
			speech_busy <= 1'b0;
		end

		// Keys and sticks under wizard of wor where fire B reads high when held
		download_write(`ASTRO_IDX_GAME, '0, 16'(GAME_WOW));
		repeat (2) @(posedge clk_sys);
		for (int i = 0; i < 18; i++) begin
			active = (key_code[i] == `ASTRO_KEY_SPACE) || (key_code[i] == `ASTRO_KEY_S);
			key_event(key_code[i], 1'b1);
			check_row_bit(key_col[i], key_bit[i], active);
			key_event(key_code[i], 1'b0);
			check_row_bit(key_col[i], key_bit[i], !active);
		end
		for (int j = 0; j < 9; j++) begin
			active = (j == `ASTRO_JOY_FIRE_B);
			@(posedge clk_sys);
			joystick_0 <= 16'd1 << j;
			check_row_bit(joy_col[j], joy_bit[j], active);
			@(posedge clk_sys);
			joystick_0 <= 16'd0;
			check_row_bit(joy_col[j], joy_bit[j], !active);
			// Player 2 stick on column 1
			if (j < 6) begin
				@(posedge clk_sys);
				joystick_1 <= 16'd1 << j;
				check_row_bit(1, joy_bit[j], active);
				@(posedge clk_sys);
				joystick_1 <= 16'd0;
				check_row_bit(1, joy_bit[j], !active);
			end
		end

		// Sample download with back-pressure
		@(posedge clk_sys);
		ioctl_download <= 1'b1;
		ioctl_index <= `ASTRO_IDX_SAMPLES;
		wave_rd <= 1'b1;
		for (int n = 0; n < LOADS; n++) begin
			sample_write(25'($urandom), $urandom_range(MAX_HOLD, 1));
		end
		// Playback path once the download ends
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		wave_addr <= 24'($urandom);
		@(negedge clk_sys);
		check_value("mem_addr", mem_addr, {1'b0, wave_addr});
		check_value("mem_rd", mem_rd, 1'b1);
		@(posedge clk_sys);
		wave_rd <= 1'b0;
		@(negedge clk_sys);
		check_value("mem_rd", mem_rd, 1'b0);

		repeat (2) @(posedge clk_sys);
		if (i_astro_controls_top.i_astro_controls_props.fail_count == 0) begin
			$display("TEST OK");
			$finish;
		end else begin
			fail_run("A bound timing assertion failed");
		end
	end

endmodule

// File: dv/astro_controls_props.sv
/*
 * Concurrent checks on reset values, the sample write pulse
 * and the download wait timing, bound into the top level
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module astro_controls_props (
	input logic        clk_sys,
	input logic        reset,
	input logic        ioctl_download,
	input logic        ioctl_wr,
	input logic [7:0]  ioctl_index,
	input logic        mem_ready,
	input logic        ioctl_wait,
	input logic        mem_we,
	input logic [15:0] audio_l,
	input logic [15:0] audio_r
);

	// Failure count read by the testbench
	int   fail_count = 0;
	logic sample_wr;

	// Strobe that belongs to a sample download
	assign sample_wr = ioctl_wr && ioctl_download && (ioctl_index == `ASTRO_IDX_SAMPLES);

	// ==================================================================
	// Reset values
	// ==================================================================
	// Quiet on every cycle that follows a cycle in reset
	a_reset_quiet: assert property (@(posedge clk_sys)
		reset |=> (!ioctl_wait && !mem_we && audio_l == '0 && audio_r == '0))
	else begin
		$error("loader or mixer output not zero around reset");
		fail_count++;
	end

	// ==================================================================
	// Loader handshake
	// ==================================================================
	// One write pulse on the cycle after the strobe
	a_write_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		(sample_wr && !ioctl_wait) |=> mem_we ##1 !mem_we)
	else begin
		$error("mem_we is not a single pulse after the sample strobe");
		fail_count++;
	end

	// Wait rises together with the write
	a_wait_rise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ioctl_wait) |-> mem_we)
	else begin
		$error("ioctl_wait rose without mem_we");
		fail_count++;
	end

	// Back-pressure holds the source
	a_wait_hold: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wait && !mem_we && !mem_ready) |=> ioctl_wait)
	else begin
		$error("ioctl_wait fell while mem_ready was low");
		fail_count++;
	end

	// Released one cycle after ready
	a_wait_release: assert property (@(posedge clk_sys) disable iff (reset)
		(ioctl_wait && !mem_we && mem_ready) |=> !ioctl_wait)
	else begin
		$error("ioctl_wait still high one cycle after mem_ready");
		fail_count++;
	end

endmodule

bind astro_controls_top astro_controls_props i_astro_controls_props (.*);

// File: hdl/astro_controls_top.sv
/*
 * Control and configuration front end: game config, keys,
 * switch matrix, sample loader and audio mixer
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module astro_controls_top import astro_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	// Download port
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [`ASTRO_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]              ioctl_dout,
	input  logic [7:0]               ioctl_index,
	output logic                     ioctl_wait,
	// Player inputs
	input  logic [10:0]              ps2_key,
	input  logic [15:0]              joystick_0,
	input  logic [15:0]              joystick_1,
	// Custom chip switch matrix
	input  logic [7:0]               col_select,
	input  logic                     speech_busy,
	output logic [7:0]               row_data,
	// Sample memory
	input  logic [`ASTRO_WAVE_W-1:0] wave_addr,
	input  logic                     wave_rd,
	input  logic                     mem_ready,
	output logic                     mem_we,
	output logic                     mem_rd,
	output logic [`ASTRO_ADDR_W-1:0] mem_addr,
	// Audio
	input  logic [7:0]               chip_l,
	input  logic [7:0]               chip_r,
	input  logic [15:0]              sample_l,
	input  logic [15:0]              sample_r,
	output logic [15:0]              audio_l,
	output logic [15:0]              audio_r,
	output logic                     audio_signed
);

	game_t       game;
	logic [63:0] dip_bank;
	logic [5:0]  p1_buttons;
	logic [5:0]  p2_buttons;
	logic        start_1;
	logic        start_2;
	logic        coin;

	game_config i_game_config (
		.clk_sys(clk_sys), .reset(reset), .ioctl_wr(ioctl_wr), .ioctl_addr(ioctl_addr),
		.ioctl_dout(ioctl_dout), .ioctl_index(ioctl_index), .game(game), .dip_bank(dip_bank)
	);

	key_decoder i_key_decoder (
		.clk_sys(clk_sys), .reset(reset), .ps2_key(ps2_key), .joystick_0(joystick_0),
		.joystick_1(joystick_1), .p1_buttons(p1_buttons), .p2_buttons(p2_buttons),
		.start_1(start_1), .start_2(start_2), .coin(coin)
	);

	switch_matrix i_switch_matrix (
		.col_select(col_select), .game(game), .dip_bank(dip_bank),
		.p1_buttons(p1_buttons), .p2_buttons(p2_buttons), .start_1(start_1),
		.start_2(start_2), .coin(coin), .speech_busy(speech_busy), .row_data(row_data)
	);

	sample_loader i_sample_loader (
		.clk_sys(clk_sys), .reset(reset), .ioctl_download(ioctl_download),
		.ioctl_wr(ioctl_wr), .ioctl_index(ioctl_index), .ioctl_addr(ioctl_addr),
		.wave_addr(wave_addr), .wave_rd(wave_rd), .mem_ready(mem_ready),
		.ioctl_wait(ioctl_wait), .mem_we(mem_we), .mem_rd(mem_rd), .mem_addr(mem_addr)
	);

	audio_mixer i_audio_mixer (
		.clk_sys(clk_sys), .reset(reset), .game(game), .chip_l(chip_l), .chip_r(chip_r),
		.sample_l(sample_l), .sample_r(sample_r), .audio_l(audio_l), .audio_r(audio_r),
		.audio_signed(audio_signed)
	);

endmodule

// File: hdl/audio_mixer.sv
/*
 * Per-game mix of sound chip output and speech samples
 */
`timescale 1ns/1ns

module audio_mixer import astro_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  game_t       game,
	input  logic [7:0]  chip_l,
	input  logic [7:0]  chip_r,
	input  logic [15:0] sample_l,
	input  logic [15:0] sample_r,
	output logic [15:0] audio_l,
	output logic [15:0] audio_r,
	output logic        audio_signed
);

	logic stereo;
	logic only_samples;
	logic plus_samples;

	// Second sound chip fitted
	assign stereo = (game == GAME_GORF) || (game == GAME_WOW) || (game == GAME_ROBBY);
	// Speech only, no sound chip
	assign only_samples = (game == GAME_SEAWOLF2);
	// Speech on top of the sound chip
	assign plus_samples = (game == GAME_GORF) || (game == GAME_WOW);
	assign audio_signed = only_samples;

	// Speech is much louder than the chip, so scale it down
	function automatic logic [15:0] mix(input logic [7:0] chip, input logic [15:0] smp);
		return {1'b0, chip, chip[7:2]} + {2'b00, smp[15:2]};
	endfunction

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			audio_l <= 16'd0;
			audio_r <= 16'd0;
		end else if (only_samples) begin
			audio_l <= sample_l;
			audio_r <= sample_r;
		end else if (plus_samples) begin
			audio_l <= mix(chip_l, sample_l);
			audio_r <= mix(chip_r, sample_r);
		end else begin
			audio_l <= {chip_l, chip_l};
			audio_r <= stereo ? {chip_r, chip_r} : {chip_l, chip_l};
		end
	end

endmodule

// File: hdl/sample_loader.sv
/*
 * Sample download pacing into external memory,
 * playback read pass-through
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module sample_loader import astro_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_download,
	input  logic                     ioctl_wr,
	input  logic [7:0]               ioctl_index,
	input  logic [`ASTRO_ADDR_W-1:0] ioctl_addr,
	input  logic [`ASTRO_WAVE_W-1:0] wave_addr,
	input  logic                     wave_rd,
	input  logic                     mem_ready,
	output logic                     ioctl_wait,
	output logic                     mem_we,
	output logic                     mem_rd,
	output logic [`ASTRO_ADDR_W-1:0] mem_addr
);

	loader_state_t state;
	loader_state_t state_next;
	logic          wav_load;

	// Sample file in progress
	assign wav_load = ioctl_download && (ioctl_index == `ASTRO_IDX_SAMPLES);

	// ==================================================================
	// Loader FSM
	// ==================================================================
	always_comb begin
		state_next = state;
		case (state)
			LD_IDLE: begin
				if (ioctl_wr && wav_load) begin
					state_next = LD_WRITE;
				end
			end
			// Single write cycle
			LD_WRITE: state_next = LD_WAIT;
			// Hold the source until memory accepts
			LD_WAIT: begin
				if (mem_ready) begin
					state_next = LD_IDLE;
				end
			end
			default: state_next = LD_IDLE;
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			state <= LD_IDLE;
		end else begin
			state <= state_next;
		end
	end

	// Write pulse and wait both come straight off the state register
	assign mem_we = (state == LD_WRITE);
	assign ioctl_wait = (state != LD_IDLE);

	// Address mux between loading and playback
	assign mem_addr = wav_load ? ioctl_addr : {1'b0, wave_addr};
	assign mem_rd = wave_rd & ~ioctl_download;

endmodule

// File: hdl/switch_matrix.sv
/*
 * Switch-matrix row multiplexer, per game and column
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module switch_matrix import astro_pkg::*; (
	input  logic [7:0]  col_select,
	input  game_t       game,
	input  logic [63:0] dip_bank,
	input  logic [5:0]  p1_buttons,
	input  logic [5:0]  p2_buttons,
	input  logic        start_1,
	input  logic        start_2,
	input  logic        coin,
	input  logic        speech_busy,
	output logic [7:0]  row_data
);

	// Active low switch levels
	logic [5:0] p1_n;
	logic [5:0] p2_n;
	logic       s1_n;
	logic       s2_n;
	logic       c_n;
	logic [7:0] dip2;
	logic [7:0] dip3;
	logic [3:0] p1_dir;
	logic [3:0] p2_dir;

	assign p1_n = ~p1_buttons;
	assign p2_n = ~p2_buttons;
	assign s1_n = ~start_1;
	assign s2_n = ~start_2;
	assign c_n = ~coin;
	assign dip2 = dip_bank[23:16];
	assign dip3 = dip_bank[31:24];

	// R, L, D, U from the top down
	assign p1_dir = {p1_n[`ASTRO_BTN_RIGHT], p1_n[`ASTRO_BTN_LEFT],
		p1_n[`ASTRO_BTN_DOWN], p1_n[`ASTRO_BTN_UP]};
	assign p2_dir = {p2_n[`ASTRO_BTN_RIGHT], p2_n[`ASTRO_BTN_LEFT],
		p2_n[`ASTRO_BTN_DOWN], p2_n[`ASTRO_BTN_UP]};

	always_comb begin
		row_data = 8'hff;
		case (col_select)
			// Start, coin and cabinet DIPs
			`ASTRO_COL_0: begin
				case (game)
					GAME_SPACEZAP: row_data = {2'b11, s2_n, s1_n, dip2[1], 1'b1, c_n, 1'b1};
					GAME_GORF: row_data = {dip2[2], dip2[0], s2_n, s1_n, 1'b1, dip2[1], c_n, 1'b1};
					GAME_WOW: row_data = {dip2[2], s2_n, s1_n, 1'b1, dip2[1], 1'b1, c_n, 1'b1};
					GAME_ROBBY: row_data = {1'b0, s2_n, s1_n, 1'b1, dip2[1], 1'b1, c_n, 1'b1};
					default: row_data = 8'hff;
				endcase
			end
			// Player 2 stick
			`ASTRO_COL_1: begin
				case (game)
					GAME_SPACEZAP: row_data = {3'b111, p2_n[`ASTRO_BTN_FIRE], p2_dir};
					GAME_GORF: row_data = {3'b001, p2_n[`ASTRO_BTN_FIRE], p2_dir};
					// Fire B reads high when held
					GAME_WOW: row_data = {2'b11, p2_n[`ASTRO_BTN_FIRE],
						p2_buttons[`ASTRO_BTN_FIRE_B], p2_dir};
					GAME_ROBBY: row_data = {2'b11, p2_n[`ASTRO_BTN_FIRE], 1'b1, p2_dir};
					default: row_data = 8'hff;
				endcase
			end
			// Player 1 stick, speech status on top for the talking games
			`ASTRO_COL_2: begin
				case (game)
					GAME_SPACEZAP: row_data = {2'b11, dip2[0], p1_n[`ASTRO_BTN_FIRE], p1_dir};
					GAME_GORF: row_data = {speech_busy, 2'b01, p1_n[`ASTRO_BTN_FIRE], p1_dir};
					GAME_WOW: row_data = {speech_busy, 1'b1, p1_n[`ASTRO_BTN_FIRE],
						p1_buttons[`ASTRO_BTN_FIRE_B], p1_dir};
					GAME_ROBBY: row_data = {2'b11, p1_n[`ASTRO_BTN_FIRE], 1'b1, p1_dir};
					default: row_data = 8'hff;
				endcase
			end
			// Extra bases uses this column for its trackball
			`ASTRO_COL_3: begin
				if (game != GAME_EBASES) begin
					row_data = dip3;
				end
			end
			default: row_data = 8'hff;
		endcase
	end

endmodule

// File: hdl/key_decoder.sv
/*
 * Keyboard scan-code decoder and per-player button merge
 * with the digital joystick words
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module key_decoder (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic [10:0] ps2_key,
	input  logic [15:0] joystick_0,
	input  logic [15:0] joystick_1,
	output logic [5:0]  p1_buttons,
	output logic [5:0]  p2_buttons,
	output logic        start_1,
	output logic        start_2,
	output logic        coin
);

	// Positions in the system key vector
	localparam int SYS_F1 = 0;
	localparam int SYS_F2 = 1;
	localparam int SYS_F3 = 2;
	localparam int SYS_1  = 3;
	localparam int SYS_2  = 4;
	localparam int SYS_5  = 5;

	logic       old_toggle;
	logic [5:0] p1_key;
	logic [5:0] p2_key;
	logic [5:0] sys_key;
	logic       pressed;
	logic [8:0] code;

	assign pressed = ps2_key[9];
	assign code = ps2_key[8:0];

	// ==================================================================
	// Event decode, one key level per table entry
	// ==================================================================
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_toggle <= 1'b0;
			p1_key <= 6'd0;
			p2_key <= 6'd0;
			sys_key <= 6'd0;
		end else begin
			old_toggle <= ps2_key[10];
			// New event whenever the toggle bit flips
			if (old_toggle != ps2_key[10]) begin
				casez (code)
					{1'b?, `ASTRO_KEY_UP}:    p1_key[`ASTRO_BTN_UP] <= pressed;
					{1'b?, `ASTRO_KEY_DOWN}:  p1_key[`ASTRO_BTN_DOWN] <= pressed;
					{1'b?, `ASTRO_KEY_LEFT}:  p1_key[`ASTRO_BTN_LEFT] <= pressed;
					{1'b?, `ASTRO_KEY_RIGHT}: p1_key[`ASTRO_BTN_RIGHT] <= pressed;
					`ASTRO_KEY_CTRL:          p1_key[`ASTRO_BTN_FIRE] <= pressed;
					`ASTRO_KEY_SPACE:         p1_key[`ASTRO_BTN_FIRE_B] <= pressed;
					`ASTRO_KEY_F1:            sys_key[SYS_F1] <= pressed;
					`ASTRO_KEY_F2:            sys_key[SYS_F2] <= pressed;
					`ASTRO_KEY_F3:            sys_key[SYS_F3] <= pressed;
					`ASTRO_KEY_1:             sys_key[SYS_1] <= pressed;
					`ASTRO_KEY_2:             sys_key[SYS_2] <= pressed;
					`ASTRO_KEY_5:             sys_key[SYS_5] <= pressed;
					// Player 2 on the arcade panel keys
					`ASTRO_KEY_R:             p2_key[`ASTRO_BTN_UP] <= pressed;
					`ASTRO_KEY_F:             p2_key[`ASTRO_BTN_DOWN] <= pressed;
					`ASTRO_KEY_D:             p2_key[`ASTRO_BTN_LEFT] <= pressed;
					`ASTRO_KEY_G:             p2_key[`ASTRO_BTN_RIGHT] <= pressed;
					`ASTRO_KEY_A:             p2_key[`ASTRO_BTN_FIRE] <= pressed;
					`ASTRO_KEY_S:             p2_key[`ASTRO_BTN_FIRE_B] <= pressed;
					default: ;
				endcase
			end
		end
	end

	// ==================================================================
	// Merge with joystick
	// ==================================================================
	function automatic logic [5:0] merge_player(input logic [5:0] keys, input logic [15:0] joy);
		logic [5:0] btn;
		btn = keys;
		btn[`ASTRO_BTN_UP] = keys[`ASTRO_BTN_UP] | joy[`ASTRO_JOY_UP];
		btn[`ASTRO_BTN_DOWN] = keys[`ASTRO_BTN_DOWN] | joy[`ASTRO_JOY_DOWN];
		btn[`ASTRO_BTN_LEFT] = keys[`ASTRO_BTN_LEFT] | joy[`ASTRO_JOY_LEFT];
		btn[`ASTRO_BTN_RIGHT] = keys[`ASTRO_BTN_RIGHT] | joy[`ASTRO_JOY_RIGHT];
		btn[`ASTRO_BTN_FIRE] = keys[`ASTRO_BTN_FIRE] | joy[`ASTRO_JOY_FIRE];
		btn[`ASTRO_BTN_FIRE_B] = keys[`ASTRO_BTN_FIRE_B] | joy[`ASTRO_JOY_FIRE_B];
		return btn;
	endfunction

	assign p1_buttons = merge_player(p1_key, joystick_0);
	assign p2_buttons = merge_player(p2_key, joystick_1);

	// Start and coin come from joystick 0 only
	assign start_1 = sys_key[SYS_F1] | sys_key[SYS_1] | joystick_0[`ASTRO_JOY_START_1];
	assign start_2 = sys_key[SYS_F2] | sys_key[SYS_2] | joystick_0[`ASTRO_JOY_START_2];
	assign coin = sys_key[SYS_F3] | sys_key[SYS_5] | joystick_0[`ASTRO_JOY_COIN];

endmodule

// File: hdl/game_config.sv
/*
 * Game selection and DIP switch bank, latched from the download port
 */
`timescale 1ns/1ns
`include "astro_settings.svh"

module game_config import astro_pkg::*; (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     ioctl_wr,
	input  logic [`ASTRO_ADDR_W-1:0] ioctl_addr,
	input  logic [15:0]              ioctl_dout,
	input  logic [7:0]               ioctl_index,
	output game_t                    game,
	output logic [63:0]              dip_bank
);

	// Raw byte as downloaded for decoding one cycle later
	logic [7:0] game_raw = 8'd0;
	logic       game_wr_q;
	logic       game_wr;
	logic       dip_wr;

	initial game = GAME_NONE;
	initial dip_bank = 64'd0;

	assign game_wr = ioctl_wr && (ioctl_index == `ASTRO_IDX_GAME);
	// Only the first eight bytes of the DIP file land in the bank
	assign dip_wr = ioctl_wr && (ioctl_index == `ASTRO_IDX_DIP) &&
		(ioctl_addr[`ASTRO_ADDR_W-1:3] == '0);

	// Decode strobe delayed to line up with the raw byte
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			game_wr_q <= 1'b0;
		end else begin
			game_wr_q <= game_wr;
		end
	end

	// Game byte capture and decode
	always @(posedge clk_sys) begin
		if (game_wr) begin
			game_raw <= ioctl_dout[7:0];
		end
		if (game_wr_q) begin
			// Codes past robby roto select nothing
			game <= (game_raw > 8'(GAME_ROBBY)) ?
				GAME_NONE : game_t'(game_raw[2:0]);
		end
	end

	// DIP byte k sits at bits 8k+7 to 8k
	always @(posedge clk_sys) begin
		if (dip_wr) begin
			dip_bank[ioctl_addr[2:0]*8 +: 8] <= ioctl_dout[7:0];
		end
	end

endmodule

// File: hdl/astro_pkg.sv
/*
 * Shared types: selected game and sample loader state
 */
package astro_pkg;

	// ==================================================================
	// Game selection, coded as in the download byte
	// ==================================================================
	typedef enum logic [2:0] {
		GAME_NONE     = 3'd0,
		GAME_EBASES   = 3'd1,
		GAME_SEAWOLF2 = 3'd2,
		GAME_SPACEZAP = 3'd3,
		GAME_GORF     = 3'd4,
		GAME_WOW      = 3'd5,
		GAME_ROBBY    = 3'd6
	} game_t;

	// ==================================================================
	// Sample loader FSM
	// ==================================================================
	// Idle until a strobe, one write cycle, then wait for memory
	typedef enum logic [1:0] {
		LD_IDLE  = 2'd0,
		LD_WRITE = 2'd1,
		LD_WAIT  = 2'd2
	} loader_state_t;

endpackage

// File: include/astro_settings.svh
/*
 * Widths, download indices, keyboard scan codes,
 * switch-matrix column codes and button bit positions
 */
`ifndef ASTRO_SETTINGS_SVH
`define ASTRO_SETTINGS_SVH

// Download port and sample memory widths
`define ASTRO_ADDR_W 25
`define ASTRO_WAVE_W 24

// Download indices
`define ASTRO_IDX_GAME    8'd1
`define ASTRO_IDX_SAMPLES 8'd2
`define ASTRO_IDX_DIP     8'd254

// Direction keys, extended bit not compared
`define ASTRO_KEY_UP    8'h75
`define ASTRO_KEY_DOWN  8'h72
`define ASTRO_KEY_LEFT  8'h6b
`define ASTRO_KEY_RIGHT 8'h74

// Player 1 fire keys and system keys
`define ASTRO_KEY_SPACE 9'h029
`define ASTRO_KEY_CTRL  9'h014
`define ASTRO_KEY_F1    9'h005
`define ASTRO_KEY_F2    9'h006
`define ASTRO_KEY_F3    9'h004
`define ASTRO_KEY_1     9'h016
`define ASTRO_KEY_2     9'h01e
`define ASTRO_KEY_5     9'h02e

// Player 2 keys, arcade panel layout
`define ASTRO_KEY_R 9'h02d
`define ASTRO_KEY_F 9'h02b
`define ASTRO_KEY_D 9'h023
`define ASTRO_KEY_G 9'h034
`define ASTRO_KEY_A 9'h01c
`define ASTRO_KEY_S 9'h01b

// One-hot column selects from the custom chip
`define ASTRO_COL_0 8'h01
`define ASTRO_COL_1 8'h02
`define ASTRO_COL_2 8'h04
`define ASTRO_COL_3 8'h08

// Player button vector
`define ASTRO_BTN_UP     0
`define ASTRO_BTN_DOWN   1
`define ASTRO_BTN_LEFT   2
`define ASTRO_BTN_RIGHT  3
`define ASTRO_BTN_FIRE   4
`define ASTRO_BTN_FIRE_B 5

// Digital joystick word
`define ASTRO_JOY_RIGHT   0
`define ASTRO_JOY_LEFT    1
`define ASTRO_JOY_DOWN    2
`define ASTRO_JOY_UP      3
`define ASTRO_JOY_FIRE    4
`define ASTRO_JOY_FIRE_B  5
`define ASTRO_JOY_START_1 6
`define ASTRO_JOY_START_2 7
`define ASTRO_JOY_COIN    8

`endif
